//--- compile.f
lstm_fixed_pkg.sv
lstm_cmd_pkg.sv
lstm_decode.sv
lstm_execute.sv
lstm_result.sv
lstm_top.sv
tb_clock.sv
tb_lstm.sv

//--- lstm_cmd_pkg.sv
package lstm_cmd_pkg;

	// host command opcodes
	typedef enum logic [1:0] {
		OP_LOAD  = 2'd0,
		OP_STEP  = 2'd1,
		OP_CLEAR = 2'd2
	} op_t;

	// which weight of a gate a LOAD writes
	typedef enum logic [1:0] {
		WK_W = 2'd0,
		WK_U = 2'd1,
		WK_B = 2'd2
	} wkind_t;

	// occupancy and credit counters
	typedef logic [2:0] cnt_t;

	// command FIFO, also the host's starting credit count
	localparam int CMD_DEPTH = 4;
	localparam int CMD_PTR_W = $clog2(CMD_DEPTH);

	// result FIFO
	localparam int RES_DEPTH = 4;
	localparam int RES_PTR_W = $clog2(RES_DEPTH);

	// result credits held by the DUT after reset
	localparam cnt_t RES_CREDITS_INIT = 3'd2;

endpackage

//--- lstm_decode.sv
`timescale 1ns/1ns

module lstm_decode (
	input  logic                 clk,
	input  logic                 i_arst_n,
	input  logic                 i_cmd_valid,
	input  lstm_cmd_pkg::op_t    i_cmd_op,
	input  lstm_fixed_pkg::gate_t i_cmd_gate,
	input  lstm_cmd_pkg::wkind_t i_cmd_kind,
	input  lstm_fixed_pkg::fix_t i_cmd_data,
	input  logic                 i_busy,
	input  logic                 i_room,
	output logic                 o_cmd_credit,
	output logic                 o_load,
	output logic                 o_step,
	output logic                 o_clear,
	output lstm_fixed_pkg::gate_t o_gate,
	output lstm_cmd_pkg::wkind_t o_kind,
	output lstm_fixed_pkg::fix_t o_data
);

	// command storage
	lstm_cmd_pkg::op_t     op_mem   [lstm_cmd_pkg::CMD_DEPTH];
	lstm_fixed_pkg::gate_t gate_mem [lstm_cmd_pkg::CMD_DEPTH];
	lstm_cmd_pkg::wkind_t  kind_mem [lstm_cmd_pkg::CMD_DEPTH];
	lstm_fixed_pkg::fix_t  data_mem [lstm_cmd_pkg::CMD_DEPTH];

	logic [lstm_cmd_pkg::CMD_PTR_W-1:0] wr_ptr_q;
	logic [lstm_cmd_pkg::CMD_PTR_W-1:0] rd_ptr_q;
	lstm_cmd_pkg::cnt_t count_q;

	logic push;
	logic pop;
	lstm_cmd_pkg::op_t head_op;

	// host only sends while holding a credit, so the FIFO never overflows
	assign push = i_cmd_valid;
	assign head_op = op_mem[rd_ptr_q];

	// a STEP also needs a free result slot
	assign pop = (count_q != '0) && !i_busy &&
		((head_op != lstm_cmd_pkg::OP_STEP) || i_room);

	// one strobe per popped command
	assign o_load  = pop && (head_op == lstm_cmd_pkg::OP_LOAD);
	assign o_step  = pop && (head_op == lstm_cmd_pkg::OP_STEP);
	assign o_clear = pop && (head_op == lstm_cmd_pkg::OP_CLEAR);
	assign o_gate  = gate_mem[rd_ptr_q];
	assign o_kind  = kind_mem[rd_ptr_q];
	assign o_data  = data_mem[rd_ptr_q];

	// every pop frees a slot for the host
	assign o_cmd_credit = pop;

	always_ff @(posedge clk) begin
		if (push) begin
			op_mem[wr_ptr_q]   <= i_cmd_op;
			gate_mem[wr_ptr_q] <= i_cmd_gate;
			kind_mem[wr_ptr_q] <= i_cmd_kind;
			data_mem[wr_ptr_q] <= i_cmd_data;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

//--- lstm_execute.sv
`timescale 1ns/1ns

module lstm_execute (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_load,
	input  logic                  i_step,
	input  logic                  i_clear,
	input  lstm_fixed_pkg::gate_t i_gate,
	input  lstm_cmd_pkg::wkind_t  i_kind,
	input  lstm_fixed_pkg::fix_t  i_data,
	output logic                  o_busy,
	output logic                  o_done,
	output lstm_fixed_pkg::fix_t  o_h,
	output lstm_fixed_pkg::fix_t  o_c
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ACT,
		ST_CELL,
		ST_OUT,
		ST_UPD,
		ST_DONE
	} state_t;

	state_t state_q;

	// weights per gate, indexed by gate_t
	lstm_fixed_pkg::fix_t w_q [lstm_fixed_pkg::GATE_N];
	lstm_fixed_pkg::fix_t u_q [lstm_fixed_pkg::GATE_N];
	lstm_fixed_pkg::fix_t b_q [lstm_fixed_pkg::GATE_N];

	// pipeline values
	lstm_fixed_pkg::fix_t pre_q [lstm_fixed_pkg::GATE_N];
	lstm_fixed_pkg::fix_t act_q [lstm_fixed_pkg::GATE_N];
	lstm_fixed_pkg::fix_t c_new_q;
	lstm_fixed_pkg::fix_t h_new_q;

	// recurrent state
	lstm_fixed_pkg::fix_t h_q;
	lstm_fixed_pkg::fix_t c_q;

	// Q8.24 multiply, full product then arithmetic shift
	function automatic lstm_fixed_pkg::fix_t fix_mul(input lstm_fixed_pkg::fix_t a,
		input lstm_fixed_pkg::fix_t b);
		lstm_fixed_pkg::prod_t p;
		p = lstm_fixed_pkg::prod_t'(a) * lstm_fixed_pkg::prod_t'(b);
		return lstm_fixed_pkg::fix_t'(p >>> lstm_fixed_pkg::FIX_FRAC);
	endfunction

	// z/4 + 0.5 clamped to [0, 1]
	function automatic lstm_fixed_pkg::fix_t hard_sig(input lstm_fixed_pkg::fix_t z);
		lstm_fixed_pkg::fix_t s;
		s = (z >>> 2) + lstm_fixed_pkg::FIX_HALF;
		if (s < 0) begin
			s = '0;
		end else if (s > lstm_fixed_pkg::FIX_ONE) begin
			s = lstm_fixed_pkg::FIX_ONE;
		end
		return s;
	endfunction

	// z clamped to [-1, 1]
	function automatic lstm_fixed_pkg::fix_t hard_tanh(input lstm_fixed_pkg::fix_t z);
		lstm_fixed_pkg::fix_t t;
		t = z;
		if (z > lstm_fixed_pkg::FIX_ONE) begin
			t = lstm_fixed_pkg::FIX_ONE;
		end else if (z < -lstm_fixed_pkg::FIX_ONE) begin
			t = -lstm_fixed_pkg::FIX_ONE;
		end
		return t;
	endfunction

	assign o_busy = (state_q != ST_IDLE);
	assign o_done = (state_q == ST_DONE);
	assign o_h = h_q;
	assign o_c = c_q;

	always_ff @(posedge clk) begin
		if (i_load) begin
			case (i_kind)
				lstm_cmd_pkg::WK_W: w_q[i_gate] <= i_data;
				lstm_cmd_pkg::WK_U: u_q[i_gate] <= i_data;
				lstm_cmd_pkg::WK_B: b_q[i_gate] <= i_data;
				default: ;
			endcase
		end
	end

	// datapath stages, one per FSM state
	always_ff @(posedge clk) begin
		case (state_q)
			ST_IDLE: begin
				// i_data is the input sample x on a STEP
				if (i_step) begin
					for (int g = 0; g < lstm_fixed_pkg::GATE_N; g++) begin
						pre_q[g] <= fix_mul(w_q[g], i_data) + fix_mul(u_q[g], h_q) + b_q[g];
					end
				end
			end
			ST_ACT: begin
				act_q[lstm_fixed_pkg::GATE_A] <= hard_tanh(pre_q[lstm_fixed_pkg::GATE_A]);
				act_q[lstm_fixed_pkg::GATE_I] <= hard_sig(pre_q[lstm_fixed_pkg::GATE_I]);
				act_q[lstm_fixed_pkg::GATE_F] <= hard_sig(pre_q[lstm_fixed_pkg::GATE_F]);
				act_q[lstm_fixed_pkg::GATE_O] <= hard_sig(pre_q[lstm_fixed_pkg::GATE_O]);
			end
			ST_CELL: begin
				c_new_q <= fix_mul(act_q[lstm_fixed_pkg::GATE_F], c_q) +
					fix_mul(act_q[lstm_fixed_pkg::GATE_I], act_q[lstm_fixed_pkg::GATE_A]);
			end
			ST_OUT: begin
				h_new_q <= fix_mul(act_q[lstm_fixed_pkg::GATE_O], hard_tanh(c_new_q));
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= ST_IDLE;
			h_q     <= '0;
			c_q     <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (i_step) begin
						state_q <= ST_ACT;
					end
					if (i_clear) begin
						h_q <= '0;
						c_q <= '0;
					end
				end
				ST_ACT:  state_q <= ST_CELL;
				ST_CELL: state_q <= ST_OUT;
				ST_OUT:  state_q <= ST_UPD;
				ST_UPD: begin
					// new state is visible together with o_done
					state_q <= ST_DONE;
					h_q     <= h_new_q;
					c_q     <= c_new_q;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- lstm_fixed_pkg.sv
package lstm_fixed_pkg;

	// signed Q8.24 word
	localparam int FIX_W = 32;
	localparam int FIX_FRAC = 24;

	// one cell has four gates
	localparam int GATE_N = 4;

	// one data word
	typedef logic signed [FIX_W-1:0] fix_t;

	// full product before rescaling
	typedef logic signed [2*FIX_W-1:0] prod_t;

	// 1.0 and 0.5 in Q8.24
	localparam fix_t FIX_ONE = fix_t'(1 << FIX_FRAC);
	localparam fix_t FIX_HALF = fix_t'(1 << (FIX_FRAC - 1));

	// gate order also indexes the weight and activation arrays
	//   a is the candidate (tanh), i/f/o are sigmoid gates
	typedef enum logic [1:0] {
		GATE_A = 2'd0,
		GATE_I = 2'd1,
		GATE_F = 2'd2,
		GATE_O = 2'd3
	} gate_t;

endpackage

//--- lstm_golden.txt
// first word: number of command lines
// columns: op gate kind data expected_h expected_c (op 0 LOAD, 1 STEP, 2 CLEAR)
1D
0 0 0 01000000 00000000 00000000
0 0 1 00000000 00000000 00000000
0 0 2 00000000 00000000 00000000
0 1 0 01000000 00000000 00000000
0 1 1 00000000 00000000 00000000
0 1 2 00000000 00000000 00000000
0 2 0 01000000 00000000 00000000
0 2 1 00000000 00000000 00000000
0 2 2 00000000 00000000 00000000
0 3 0 01000000 00000000 00000000
0 3 1 00800000 00000000 00000000
0 3 2 00000000 00000000 00000000
1 0 0 00800000 00320000 00500000
1 0 0 00800000 00546C80 00820000
1 0 0 FF800000 00004FEA 0000C000
2 0 0 00000000 00000000 00000000
1 0 0 00800000 00320000 00500000
1 0 0 08000000 01000000 01500000
1 0 0 F8000000 00000000 00000000
1 0 0 08000000 01000000 01000000
1 0 0 08000000 01000000 02000000
1 0 0 08000000 01000000 03000000
1 0 0 08000000 01000000 04000000
1 0 0 08000000 01000000 05000000
1 0 0 08000000 01000000 06000000
1 0 0 08000000 01000000 07000000
1 0 0 08000000 01000000 08000000
1 0 0 08000000 01000000 09000000
1 0 0 08000000 01000000 0A000000

//--- lstm_result.sv
`timescale 1ns/1ns

module lstm_result (
	input  logic                 clk,
	input  logic                 i_arst_n,
	input  logic                 i_done,
	input  lstm_fixed_pkg::fix_t i_h,
	input  lstm_fixed_pkg::fix_t i_c,
	input  logic                 i_res_credit,
	output logic                 o_room,
	output logic                 o_res_valid,
	output lstm_fixed_pkg::fix_t o_res_h,
	output lstm_fixed_pkg::fix_t o_res_c
);

	lstm_fixed_pkg::fix_t h_mem [lstm_cmd_pkg::RES_DEPTH];
	lstm_fixed_pkg::fix_t c_mem [lstm_cmd_pkg::RES_DEPTH];

	logic [lstm_cmd_pkg::RES_PTR_W-1:0] wr_ptr_q;
	logic [lstm_cmd_pkg::RES_PTR_W-1:0] rd_ptr_q;
	lstm_cmd_pkg::cnt_t count_q;
	lstm_cmd_pkg::cnt_t credit_q;

	logic pop;

	// decode holds STEPs while full, so a push always finds a slot
	assign o_room = (count_q < lstm_cmd_pkg::RES_DEPTH);

	// head goes out while the consumer has granted a credit
	assign pop = (count_q != '0) && (credit_q != '0);
	assign o_res_valid = pop;
	assign o_res_h = h_mem[rd_ptr_q];
	assign o_res_c = c_mem[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (i_done) begin
			h_mem[wr_ptr_q] <= i_h;
			c_mem[wr_ptr_q] <= i_c;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= lstm_cmd_pkg::RES_CREDITS_INIT;
		end else begin
			if (i_done) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({i_done, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			// returned credit and spent credit can cancel out
			case ({i_res_credit, pop})
				2'b10: credit_q <= credit_q + 1'b1;
				2'b01: credit_q <= credit_q - 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

endmodule

//--- lstm_top.sv
`timescale 1ns/1ns

module lstm_top (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_cmd_valid,
	input  lstm_cmd_pkg::op_t     i_cmd_op,
	input  lstm_fixed_pkg::gate_t i_cmd_gate,
	input  lstm_cmd_pkg::wkind_t  i_cmd_kind,
	input  lstm_fixed_pkg::fix_t  i_cmd_data,
	input  logic                  i_res_credit,
	output logic                  o_cmd_credit,
	output logic                  o_res_valid,
	output lstm_fixed_pkg::fix_t  o_res_h,
	output lstm_fixed_pkg::fix_t  o_res_c
);

	// decode to execute
	logic                  load;
	logic                  step;
	logic                  clear;
	lstm_fixed_pkg::gate_t gate;
	lstm_cmd_pkg::wkind_t  kind;
	lstm_fixed_pkg::fix_t  data;

	// back-pressure into decode
	logic busy;
	logic room;

	// execute to result
	logic                 done;
	lstm_fixed_pkg::fix_t h;
	lstm_fixed_pkg::fix_t c;

	lstm_decode lstm_decode_inst (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_cmd_valid  (i_cmd_valid),
		.i_cmd_op     (i_cmd_op),
		.i_cmd_gate   (i_cmd_gate),
		.i_cmd_kind   (i_cmd_kind),
		.i_cmd_data   (i_cmd_data),
		.i_busy       (busy),
		.i_room       (room),
		.o_cmd_credit (o_cmd_credit),
		.o_load       (load),
		.o_step       (step),
		.o_clear      (clear),
		.o_gate       (gate),
		.o_kind       (kind),
		.o_data       (data)
	);

	lstm_execute lstm_execute_inst (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_load   (load),
		.i_step   (step),
		.i_clear  (clear),
		.i_gate   (gate),
		.i_kind   (kind),
		.i_data   (data),
		.o_busy   (busy),
		.o_done   (done),
		.o_h      (h),
		.o_c      (c)
	);

	lstm_result lstm_result_inst (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_done       (done),
		.i_h          (h),
		.i_c          (c),
		.i_res_credit (i_res_credit),
		.o_room       (room),
		.o_res_valid  (o_res_valid),
		.o_res_h      (o_res_h),
		.o_res_c      (o_res_c)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the LSTM testbench, pass is decided from the log
rm -f sim.log
( verilator --binary --timing -Wno-fatal --top-module tb_lstm -f compile.f \
	&& ./obj_dir/Vtb_lstm ) > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic o_clk
);

	// 4 ns period
	initial begin
		o_clk = 1'b0;
	end

	always #2 o_clk = ~o_clk;

endmodule

//--- tb_lstm.sv
`timescale 1ns/1ns

module tb_lstm;

	// first STEP of the back-pressure group in the golden file
	localparam int HOLD_FROM = 19;
	localparam int GOLD_WORDS = 512;

	logic                  clk;
	logic                  arst_n;
	logic                  cmd_valid;
	lstm_cmd_pkg::op_t     cmd_op;
	lstm_fixed_pkg::gate_t cmd_gate;
	lstm_cmd_pkg::wkind_t  cmd_kind;
	lstm_fixed_pkg::fix_t  cmd_data;
	logic                  res_credit;
	logic                  cmd_credit;
	logic                  res_valid;
	lstm_fixed_pkg::fix_t  res_h;
	lstm_fixed_pkg::fix_t  res_c;

	logic [31:0] gold [GOLD_WORDS];
	lstm_fixed_pkg::fix_t exp_h_q [$];
	lstm_fixed_pkg::fix_t exp_c_q [$];

	int n_lines = 0;
	int credits = lstm_cmd_pkg::CMD_DEPTH;
	int returned = 0;
	int sent = 0;
	int results = 0;
	int owed = 0;
	int quiet = 0;
	bit hold = 1'b0;

	tb_clock tb_clock_inst (
		.o_clk (clk)
	);

	lstm_top lstm_top_inst (
		.clk          (clk),
		.i_arst_n     (arst_n),
		.i_cmd_valid  (cmd_valid),
		.i_cmd_op     (cmd_op),
		.i_cmd_gate   (cmd_gate),
		.i_cmd_kind   (cmd_kind),
		.i_cmd_data   (cmd_data),
		.i_res_credit (res_credit),
		.o_cmd_credit (cmd_credit),
		.o_res_valid  (res_valid),
		.o_res_h      (res_h),
		.o_res_c      (res_c)
	);

	task automatic abort(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_fix(input string name, input lstm_fixed_pkg::fix_t got,
		input lstm_fixed_pkg::fix_t exp);
		if (got !== exp) begin
			abort($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			abort($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// one golden line, called 1 ns after a rising edge
	task automatic send_line(input int n);
		int base;
		base = 1 + n * 6;
		while (credits == 0) begin
			@(posedge clk);
			#1;
		end
		cmd_valid = 1'b1;
		cmd_op    = lstm_cmd_pkg::op_t'(gold[base][1:0]);
		cmd_gate  = lstm_fixed_pkg::gate_t'(gold[base+1][1:0]);
		cmd_kind  = lstm_cmd_pkg::wkind_t'(gold[base+2][1:0]);
		cmd_data  = gold[base+3];
		credits--;
		sent++;
		if (cmd_op == lstm_cmd_pkg::OP_STEP) begin
			exp_h_q.push_back(gold[base+4]);
			exp_c_q.push_back(gold[base+5]);
		end
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic send_range(input int first, input int last);
		for (int n = first; n < last; n++) begin
			send_line(n);
		end
	endtask

	task automatic wait_drained();
		while (exp_h_q.size() != 0 || owed != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	// outputs are sampled mid-cycle
	always @(negedge clk) begin
		if (arst_n) begin
			if (cmd_credit) begin
				credits++;
				returned++;
				quiet = 0;
			end else begin
				quiet++;
			end
			if (res_valid) begin
				if (exp_h_q.size() == 0) begin
					abort("a result arrived with no STEP outstanding");
				end else begin
					check_fix("o_res_h", res_h, exp_h_q.pop_front());
					check_fix("o_res_c", res_c, exp_c_q.pop_front());
					results++;
					owed++;
				end
			end
		end
	end

	// consumer returns credits after a short random gap
	initial begin
		int gap;
		gap = 0;
		forever begin
			@(posedge clk);
			#1;
			res_credit = 1'b0;
			if (!hold && owed > 0) begin
				if (gap == 0) begin
					res_credit = 1'b1;
					owed--;
					gap = $urandom % 4;
				end else begin
					gap--;
				end
			end
		end
	end

	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 40 + 200) @(posedge clk);
		abort("timeout, the DUT stopped answering before all results arrived");
	end

	initial begin
		int held_base;
		void'($urandom(84282));
		arst_n     = 1'b0;
		cmd_valid  = 1'b0;
		cmd_op     = lstm_cmd_pkg::OP_LOAD;
		cmd_gate   = lstm_fixed_pkg::GATE_A;
		cmd_kind   = lstm_cmd_pkg::WK_W;
		cmd_data   = '0;
		res_credit = 1'b0;
		$readmemh("lstm_golden.txt", gold);
		n_lines = int'(gold[0]);
		if (n_lines <= 0 || 1 + n_lines * 6 > GOLD_WORDS) begin
			abort("the golden file is missing or gives a bad number of command lines");
		end
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// idle outputs before any command
		repeat (4) begin
			@(negedge clk);
			check_bit("o_res_valid", res_valid, 1'b0);
			check_bit("o_cmd_credit", cmd_credit, 1'b0);
		end
		@(posedge clk);
		#1;

		// first burst uses up the host credits
		send_range(0, lstm_cmd_pkg::CMD_DEPTH);
		while (credits != lstm_cmd_pkg::CMD_DEPTH) begin
			@(posedge clk);
			#1;
		end
		// a stray extra credit would show up in these cycles
		repeat (4) @(posedge clk);
		#1;
		check_count("command credits back", returned, lstm_cmd_pkg::CMD_DEPTH);

		send_range(lstm_cmd_pkg::CMD_DEPTH, HOLD_FROM);
		wait_drained();
		repeat (2) @(posedge clk);
		#1;

		// result credits held back until the whole chain stalls
		hold = 1'b1;
		held_base = results;
		quiet = 0;
		fork
			send_range(HOLD_FROM, n_lines);
		join_none
		while (quiet < 40) begin
			@(posedge clk);
			#1;
		end
		check_count("results while held", results - held_base,
			int'(lstm_cmd_pkg::RES_CREDITS_INIT));
		check_count("host command credits while held", credits, 0);
		hold = 1'b0;

		while (sent != n_lines) begin
			@(posedge clk);
			#1;
		end
		wait_drained();
		repeat (4) @(posedge clk);
		check_count("command credits total", returned, sent);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
